// File: common/mcm_settings.svh
`ifndef MCM_SETTINGS_SVH
`define MCM_SETTINGS_SVH

// ****************************************
// hub size
// ****************************************

// motion slots on the backplane
`define MCM_NUM_SLOTS 4

// ****************************************
// spi frame layout, msb first
// ****************************************

`define MCM_CMD_WIDTH 16
`define MCM_ADDR_WIDTH 8
`define MCM_DATA_WIDTH 40
// cmd + addr + data
`define MCM_FRAME_BITS 64

// ****************************************
// per slot sensing
// ****************************************

// encoder position, wraps modulo 2^32
`define MCM_QUAD_WIDTH 32
// ul, ll, index
`define MCM_INTRPTS_PER_SLOT 3

`endif

// File: common/mcm_pkg.sv
`include "mcm_settings.svh"

package mcm_pkg;

	// ****************************************
	// host command set
	// ****************************************

	typedef enum logic [`MCM_CMD_WIDTH-1:0] {
		CMD_NOP               = 16'd0,
		CMD_SET_QUAD_COUNT    = 16'd1,
		CMD_REQ_QUAD_COUNT    = 16'd2,
		CMD_SET_INTRPT_MASK   = 16'd3,
		CMD_REQ_INTRPT_STATUS = 16'd4,
		CMD_CLR_INTRPT        = 16'd5
	} spi_cmd_e;

	// cmd in the top bits, shifted first
	typedef struct packed {
		spi_cmd_e                    cmd;
		logic [`MCM_ADDR_WIDTH-1:0]  addr;
		logic [`MCM_DATA_WIDTH-1:0]  data;
	} spi_frame_t;

	// serial slave states
	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_SHIFT,
		SPI_DONE
	} spi_state_e;

	// ****************************************
	// slot side types
	// ****************************************

	typedef logic [`MCM_QUAD_WIDTH-1:0] quad_count_t;

	typedef struct packed {
		logic a;
		logic b;
	} quad_pins_t;

	typedef struct packed {
		logic ul;
		logic ll;
		logic index;
	} limit_pins_t;

	// bit 0 ul, bit 1 ll, bit 2 index
	typedef logic [`MCM_INTRPTS_PER_SLOT-1:0] intrpt_status_t;

	typedef logic [`MCM_NUM_SLOTS-1:0] slot_mask_t;

endpackage

// File: spi/spi_slave.sv
`include "mcm_settings.svh"
`timescale 1ns/1ps

module spi_slave
	import mcm_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       spi_clk_i,
	input  logic       spi_scsn_i,
	input  logic       spi_mosi_i,
	output logic       spi_miso_o,
	input  spi_frame_t reply_frame_i,
	output spi_frame_t cmd_frame_o,
	output logic       cmd_valid_o
);

	localparam int CNT_W = $clog2(`MCM_FRAME_BITS) + 1;
	localparam logic [CNT_W-1:0] FRAME_CNT = CNT_W'(`MCM_FRAME_BITS);
	// pin order 2 mosi, 1 scsn, 0 spi clock
	// chip select idles high so no false frame start out of reset
	localparam logic [2:0] PIN_IDLE = 3'b010;

	logic [2:0]                 pin_meta_q;
	logic [2:0]                 pin_sync_q;
	logic [2:0]                 pin_prev_q;
	logic                       sclk_rise;
	logic                       sclk_fall;
	logic                       scsn_rise;
	logic                       scsn_fall;
	logic                       mosi_s;
	logic                       frame_start;
	spi_state_e                 state_q;
	logic [CNT_W-1:0]           bit_cnt_q;
	logic [`MCM_FRAME_BITS-1:0] rx_q;
	logic [`MCM_FRAME_BITS-1:0] tx_q;
	logic [`MCM_FRAME_BITS-1:0] reply_bits;

	// ****************************************
	// pin synchronizers and edges
	// ****************************************

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			pin_meta_q <= PIN_IDLE;
			pin_sync_q <= PIN_IDLE;
			pin_prev_q <= PIN_IDLE;
		end
		else
		begin
			pin_meta_q <= {spi_mosi_i, spi_scsn_i, spi_clk_i};
			pin_sync_q <= pin_meta_q;
			// one more stage, only for edge detect
			pin_prev_q <= pin_sync_q;
		end
	end

	assign sclk_rise = pin_sync_q[0] & ~pin_prev_q[0];
	assign sclk_fall = ~pin_sync_q[0] & pin_prev_q[0];
	assign scsn_rise = pin_sync_q[1] & ~pin_prev_q[1];
	assign scsn_fall = ~pin_sync_q[1] & pin_prev_q[1];
	assign mosi_s    = pin_sync_q[2];

	// a select falling mid frame is ignored
	assign frame_start = scsn_fall && (state_q != SPI_SHIFT);
	assign reply_bits  = reply_frame_i;

	// ****************************************
	// frame fsm
	// ****************************************

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q   <= SPI_IDLE;
			bit_cnt_q <= '0;
		end
		else
		begin
			case (state_q)
				SPI_SHIFT:
				begin
					// only an exact 64 bit frame gets through
					if (scsn_rise)
						state_q <= (bit_cnt_q == FRAME_CNT) ? SPI_DONE : SPI_IDLE;
					// saturate so overlong frames can never wrap back to 64
					else if (sclk_rise && (bit_cnt_q != '1))
						bit_cnt_q <= bit_cnt_q + 1'b1;
				end
				default:
				begin
					// done lasts one cycle, a new select can follow right away
					if (frame_start)
					begin
						state_q   <= SPI_SHIFT;
						bit_cnt_q <= '0;
					end
					else
						state_q <= SPI_IDLE;
				end
			endcase
		end
	end

	// ****************************************
	// miso and shift registers
	// ****************************************

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			spi_miso_o <= 1'b0;
		else if (frame_start)
			// first bit must sit on miso before the first rising edge
			spi_miso_o <= reply_bits[`MCM_FRAME_BITS-1];
		else if ((state_q == SPI_SHIFT) && scsn_rise)
			spi_miso_o <= 1'b0;
		else if ((state_q == SPI_SHIFT) && sclk_fall)
			spi_miso_o <= tx_q[`MCM_FRAME_BITS-2];
	end

	always_ff @(posedge clk)
	begin
		// reply latched at select fall, held through the frame
		if (frame_start)
			tx_q <= reply_bits;
		else if ((state_q == SPI_SHIFT) && sclk_fall)
			tx_q <= {tx_q[`MCM_FRAME_BITS-2:0], 1'b0};

		// mosi sampled on rising spi clock
		if ((state_q == SPI_SHIFT) && sclk_rise)
			rx_q <= {rx_q[`MCM_FRAME_BITS-2:0], mosi_s};
	end

	// rx_q holds still outside shift, so the frame is stable at the strobe
	assign cmd_frame_o = spi_frame_t'(rx_q);
	assign cmd_valid_o = (state_q == SPI_DONE);

	// slots act once per frame, a double strobe would apply a command twice
	a_valid_single: assert property (@(posedge clk) disable iff (!rst_n_i)
		cmd_valid_o |=> !cmd_valid_o)
		else $error("cmd_valid_o held high for two cycles");

endmodule

// File: slot/quad_decoder.sv
`include "mcm_settings.svh"
`timescale 1ns/1ps

module quad_decoder
	import mcm_pkg::*;
#(
	parameter int SLOT_ID = 0
)
(
	input  logic        clk,
	input  logic        rst_n_i,
	input  quad_pins_t  quad_i,
	input  spi_frame_t  cmd_frame_i,
	input  logic        cmd_valid_i,
	output quad_count_t count_o
);

	localparam logic [`MCM_ADDR_WIDTH-1:0] SLOT_ADDR = `MCM_ADDR_WIDTH'(SLOT_ID);

	quad_pins_t meta_q;
	quad_pins_t sync_q;
	quad_pins_t prev_q;
	logic       step_up;
	logic       step_dn;
	logic       load;

	// ****************************************
	// encoder pin sync
	// ****************************************

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			meta_q <= '0;
			sync_q <= '0;
			prev_q <= '0;
		end
		else
		begin
			meta_q <= quad_i;
			sync_q <= meta_q;
			prev_q <= sync_q;
		end
	end

	// x4 decode on {prev a b, new a b}
	// forward cycle 00 10 11 01, a leads b
	always_comb
	begin
		step_up = 1'b0;
		step_dn = 1'b0;
		case ({prev_q, sync_q})
			4'b0010, 4'b1011, 4'b1101, 4'b0100: step_up = 1'b1;
			4'b0001, 4'b0111, 4'b1110, 4'b1000: step_dn = 1'b1;
			// no change, or both pins flipped and direction unknown
			default: step_up = 1'b0;
		endcase
	end

	assign load = cmd_valid_i && (cmd_frame_i.cmd == CMD_SET_QUAD_COUNT) &&
		(cmd_frame_i.addr == SLOT_ADDR);

	// ****************************************
	// position counter
	// ****************************************

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			count_o <= '0;
		else if (load)
			// host value wins over a step in the same cycle
			count_o <= cmd_frame_i.data[`MCM_QUAD_WIDTH-1:0];
		else if (step_up)
			count_o <= count_o + 1'b1;
		else if (step_dn)
			count_o <= count_o - 1'b1;
	end

	// a step lost under a host load leaves the count off by one
	a_load_no_step: assert property (@(posedge clk) disable iff (!rst_n_i)
		load |-> !(step_up || step_dn))
		else $error("slot %0d: count load collides with a quadrature step", SLOT_ID);

endmodule

// File: slot/intrpt_ctrl.sv
`include "mcm_settings.svh"
`timescale 1ns/1ps

module intrpt_ctrl
	import mcm_pkg::*;
#(
	parameter int SLOT_ID = 0
)
(
	input  logic           clk,
	input  logic           rst_n_i,
	input  limit_pins_t    limit_i,
	input  spi_frame_t     cmd_frame_i,
	input  logic           cmd_valid_i,
	output intrpt_status_t status_o,
	output logic           intrpt_o
);

	localparam logic [`MCM_ADDR_WIDTH-1:0] SLOT_ADDR = `MCM_ADDR_WIDTH'(SLOT_ID);

	intrpt_status_t meta_q;
	intrpt_status_t sync_q;
	intrpt_status_t prev_q;
	intrpt_status_t rise;
	intrpt_status_t clr;
	intrpt_status_t mask_q;
	intrpt_status_t mask_d;
	logic           hit;

	// ****************************************
	// limit line sync
	// ****************************************

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			meta_q <= '0;
			sync_q <= '0;
			prev_q <= '0;
		end
		else
		begin
			// reorder into status bit positions
			meta_q <= {limit_i.index, limit_i.ll, limit_i.ul};
			sync_q <= meta_q;
			prev_q <= sync_q;
		end
	end

	assign rise = sync_q & ~prev_q;

	// host commands for this slot only
	assign hit = cmd_valid_i && (cmd_frame_i.addr == SLOT_ADDR);
	assign clr = (hit && (cmd_frame_i.cmd == CMD_CLR_INTRPT)) ?
		cmd_frame_i.data[`MCM_INTRPTS_PER_SLOT-1:0] : '0;
	assign mask_d = (hit && (cmd_frame_i.cmd == CMD_SET_INTRPT_MASK)) ?
		cmd_frame_i.data[`MCM_INTRPTS_PER_SLOT-1:0] : mask_q;

	// ****************************************
	// sticky status and interrupt
	// ****************************************

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			status_o <= '0;
			mask_q   <= '0;
			intrpt_o <= 1'b0;
		end
		else
		begin
			// a fresh edge beats a clear in the same cycle
			status_o <= (status_o & ~clr) | rise;
			mask_q   <= mask_d;
			// new edges reach the pin a cycle after status, clears drop it with status
			intrpt_o <= |(status_o & ~clr & mask_d);
		end
	end

	a_intrpt_has_cause: assert property (@(posedge clk) disable iff (!rst_n_i)
		intrpt_o |-> |(status_o & mask_q))
		else $error("slot %0d: interrupt without a masked status bit", SLOT_ID);

endmodule

// File: src/reply_builder.sv
`include "mcm_settings.svh"
`timescale 1ns/1ps

module reply_builder
	import mcm_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n_i,
	input  spi_frame_t     cmd_frame_i,
	input  logic           cmd_valid_i,
	input  quad_count_t    counts_i [`MCM_NUM_SLOTS],
	input  intrpt_status_t statuses_i [`MCM_NUM_SLOTS],
	output spi_frame_t     reply_frame_o
);

	localparam int IDX_W = $clog2(`MCM_NUM_SLOTS);

	logic [IDX_W-1:0]           idx;
	logic                       in_range;
	logic                       is_req;
	logic [`MCM_DATA_WIDTH-1:0] data_d;

	// ****************************************
	// reply data select
	// ****************************************

	assign idx      = cmd_frame_i.addr[IDX_W-1:0];
	assign in_range = (cmd_frame_i.addr < `MCM_NUM_SLOTS);

	always_comb
	begin
		is_req = 1'b0;
		data_d = '0;
		case (cmd_frame_i.cmd)
			CMD_REQ_QUAD_COUNT:
			begin
				is_req = 1'b1;
				if (in_range)
					data_d = {{(`MCM_DATA_WIDTH-`MCM_QUAD_WIDTH){1'b0}}, counts_i[idx]};
			end
			CMD_REQ_INTRPT_STATUS:
			begin
				is_req = 1'b1;
				if (in_range)
					data_d = {{(`MCM_DATA_WIDTH-`MCM_INTRPTS_PER_SLOT){1'b0}},
						statuses_i[idx]};
			end
			// set and clear commands leave the reply as it was
			default: is_req = 1'b0;
		endcase
	end

	// held until the next request, shifted out in the following frame
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			reply_frame_o <= '0;
		else if (cmd_valid_i && is_req)
		begin
			// echo so the host can match reply to request
			reply_frame_o.cmd  <= cmd_frame_i.cmd;
			reply_frame_o.addr <= cmd_frame_i.addr;
			reply_frame_o.data <= data_d;
		end
	end

endmodule

// File: src/mcm_top.sv
`include "mcm_settings.svh"
`timescale 1ns/1ps

module mcm_top
	import mcm_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        spi_clk_i,
	input  logic        spi_scsn_i,
	input  logic        spi_mosi_i,
	output logic        spi_miso_o,
	input  quad_pins_t  quad_i [`MCM_NUM_SLOTS],
	input  limit_pins_t limit_i [`MCM_NUM_SLOTS],
	output slot_mask_t  intrpt_o
);

	spi_frame_t     cmd_frame;
	logic           cmd_valid;
	spi_frame_t     reply_frame;
	quad_count_t    counts [`MCM_NUM_SLOTS];
	intrpt_status_t statuses [`MCM_NUM_SLOTS];

	// ****************************************
	// host link
	// ****************************************

	spi_slave i_spi_slave (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.spi_clk_i     (spi_clk_i),
		.spi_scsn_i    (spi_scsn_i),
		.spi_mosi_i    (spi_mosi_i),
		.spi_miso_o    (spi_miso_o),
		.reply_frame_i (reply_frame),
		.cmd_frame_o   (cmd_frame),
		.cmd_valid_o   (cmd_valid)
	);

	// ****************************************
	// per slot sensing
	// ****************************************

	// each slot decodes its own address from the broadcast frame
	for (genvar slot = 0; slot < `MCM_NUM_SLOTS; slot++)
	begin : g_slot
		quad_decoder #(
			.SLOT_ID (slot)
		) i_quad_decoder (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.quad_i      (quad_i[slot]),
			.cmd_frame_i (cmd_frame),
			.cmd_valid_i (cmd_valid),
			.count_o     (counts[slot])
		);

		intrpt_ctrl #(
			.SLOT_ID (slot)
		) i_intrpt_ctrl (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.limit_i     (limit_i[slot]),
			.cmd_frame_i (cmd_frame),
			.cmd_valid_i (cmd_valid),
			.status_o    (statuses[slot]),
			.intrpt_o    (intrpt_o[slot])
		);
	end

	// answers go out one frame later
	reply_builder i_reply_builder (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cmd_frame_i   (cmd_frame),
		.cmd_valid_i   (cmd_valid),
		.counts_i      (counts),
		.statuses_i    (statuses),
		.reply_frame_o (reply_frame)
	);

endmodule

// File: testbench/tb_mcm_top.sv
`include "mcm_settings.svh"
`timescale 1ns/1ps

module tb_mcm_top
	import mcm_pkg::*;
();

	logic        clk;
	logic        rst_n;
	logic        spi_clk;
	logic        spi_scsn;
	logic        spi_mosi;
	logic        spi_miso;
	quad_pins_t  quad [`MCM_NUM_SLOTS];
	limit_pins_t limit [`MCM_NUM_SLOTS];
	slot_mask_t  intrpt;

	logic [31:0] rand_state;
	quad_count_t loaded [`MCM_NUM_SLOTS];
	int          quad_phase [`MCM_NUM_SLOTS];
	int          errors;
	int          tests_passed;
	int          tests_failed;

	mcm_top i_mcm_top (
		.clk        (clk),
		.rst_n_i    (rst_n),
		.spi_clk_i  (spi_clk),
		.spi_scsn_i (spi_scsn),
		.spi_mosi_i (spi_mosi),
		.spi_miso_o (spi_miso),
		.quad_i     (quad),
		.limit_i    (limit),
		.intrpt_o   (intrpt)
	);

	always #5 clk = ~clk;

	// ****************************************
	// helpers
	// ****************************************

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic spi_frame_t make_frame(spi_cmd_e cmd, int addr,
		logic [`MCM_DATA_WIDTH-1:0] data);
		spi_frame_t f;
		f.cmd  = cmd;
		f.addr = `MCM_ADDR_WIDTH'(addr);
		f.data = data;
		return f;
	endfunction

	// forward order 00 10 11 01 on {a, b}
	function automatic quad_pins_t phase_pins(int phase);
		quad_pins_t p;
		p.a = (phase == 1) || (phase == 2);
		p.b = (phase == 2) || (phase == 3);
		return p;
	endfunction

	task automatic check_count(input string name, input quad_count_t exp, input quad_count_t act);
		if (act !== exp)
		begin
			errors++;
			$display("Fail %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input intrpt_status_t exp,
		input intrpt_status_t act);
		if (act !== exp)
		begin
			errors++;
			$display("Fail %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_intrpt(input slot_mask_t exp);
		if (intrpt !== exp)
		begin
			errors++;
			$display("Fail intrpt_o: expected %h, got %h", exp, intrpt);
		end
	endtask

	task automatic check_frame(input string name, input spi_frame_t exp, input spi_frame_t act);
		if (act !== exp)
		begin
			errors++;
			$display("Fail %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before)
		begin
			tests_passed++;
			$display("test %s: pass", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: fail", name);
		end
	endtask

	// ****************************************
	// spi host model, mode 0
	// ****************************************

	// 5 clk per half period, nbits below 64 cuts the frame short
	task automatic spi_xfer(input spi_frame_t tx, input int nbits, output spi_frame_t rx);
		logic [`MCM_FRAME_BITS-1:0] tx_bits;
		logic [`MCM_FRAME_BITS-1:0] rx_bits;
		int                         i;
		tx_bits = tx;
		rx_bits = '0;
		@(posedge clk);
		spi_scsn <= 1'b0;
		spi_mosi <= tx_bits[`MCM_FRAME_BITS-1];
		for (i = 0; i < nbits; i++)
		begin
			repeat (4) @(posedge clk);
			// miso settled since the last falling edge
			@(negedge clk);
			rx_bits = {rx_bits[`MCM_FRAME_BITS-2:0], spi_miso};
			@(posedge clk);
			spi_clk <= 1'b1;
			repeat (5) @(posedge clk);
			spi_clk <= 1'b0;
			tx_bits = {tx_bits[`MCM_FRAME_BITS-2:0], 1'b0};
			spi_mosi <= tx_bits[`MCM_FRAME_BITS-1];
		end
		repeat (5) @(posedge clk);
		spi_scsn <= 1'b1;
		spi_mosi <= 1'b0;
		// strobe and reply update land well inside this gap
		repeat (12) @(posedge clk);
		rx = rx_bits;
	endtask

	task automatic send_cmd(input spi_cmd_e cmd, input int addr,
		input logic [`MCM_DATA_WIDTH-1:0] data);
		spi_frame_t unused_reply;
		spi_xfer(make_frame(cmd, addr, data), `MCM_FRAME_BITS, unused_reply);
	endtask

	// answer comes back in the nop frame after the request
	task automatic request(input spi_cmd_e cmd, input int addr, output spi_frame_t reply);
		send_cmd(cmd, addr, '0);
		spi_xfer(make_frame(CMD_NOP, 0, '0), `MCM_FRAME_BITS, reply);
	endtask

	// one quadrature move, 8 clk per step
	task automatic step_quad(input int slot, input int delta);
		quad_phase[slot] = (quad_phase[slot] + delta) & 3;
		@(posedge clk);
		quad[slot] <= phase_pins(quad_phase[slot]);
		repeat (7) @(posedge clk);
	endtask

	task automatic set_limit(input int slot, input limit_pins_t pins);
		@(posedge clk);
		limit[slot] <= pins;
	endtask

	task automatic wait_intrpt(input int slot, input logic level, input int limit_cycles);
		logic found;
		int   cnt;
		found = 1'b0;
		for (cnt = 0; (cnt < limit_cycles) && !found; cnt++)
		begin
			@(negedge clk);
			if (intrpt[slot] == level)
				found = 1'b1;
		end
		if (!found)
		begin
			errors++;
			$display("timeout: intrpt_o[%0d] did not go to %0b within %0d cycles",
				slot, level, limit_cycles);
		end
	endtask

	// ****************************************
	// tests
	// ****************************************

	task automatic test_reset();
		int         e;
		spi_frame_t reply;
		e = errors;
		check_intrpt('0);
		spi_xfer(make_frame(CMD_NOP, 0, '0), `MCM_FRAME_BITS, reply);
		check_frame("reply_frame", '0, reply);
		report_test("reset", e);
	endtask

	task automatic test_count_load();
		int          e;
		int          s;
		quad_count_t value;
		spi_frame_t  reply;
		e = errors;
		for (s = 0; s < `MCM_NUM_SLOTS; s++)
		begin
			value = next_rand();
			loaded[s] = value;
			// upper data byte is not part of the count
			send_cmd(CMD_SET_QUAD_COUNT, s, {8'ha5, value});
			request(CMD_REQ_QUAD_COUNT, s, reply);
			check_frame("reply_frame", make_frame(CMD_REQ_QUAD_COUNT, s, {8'h00, value}), reply);
			check_count("count_o", value, reply.data[`MCM_QUAD_WIDTH-1:0]);
		end
		report_test("count_load", e);
	endtask

	task automatic test_quad_steps();
		int          e;
		int          n;
		int          m;
		int          i;
		quad_count_t exp;
		spi_frame_t  reply;
		e = errors;
		n = int'(next_rand() % 32'd20) + 5;
		m = int'(next_rand() % 32'd10) + 1;
		for (i = 0; i < n; i++)
			step_quad(1, 1);
		// both pins at once, direction unknown
		step_quad(1, 2);
		for (i = 0; i < m; i++)
			step_quad(1, -1);
		exp = loaded[1] + quad_count_t'(n) - quad_count_t'(m);
		request(CMD_REQ_QUAD_COUNT, 1, reply);
		check_count("count_o", exp, reply.data[`MCM_QUAD_WIDTH-1:0]);
		loaded[1] = exp;
		report_test("quad_steps", e);
	endtask

	task automatic test_interrupts();
		int          e;
		limit_pins_t pins;
		spi_frame_t  reply;
		e = errors;
		// mask bit 0 ul, bit 2 index
		send_cmd(CMD_SET_INTRPT_MASK, 2, 40'h5);

		// ll is masked off
		pins = '0;
		pins.ll = 1'b1;
		set_limit(2, pins);
		repeat (8) @(posedge clk);
		check_intrpt('0);
		set_limit(2, '0);

		pins = '0;
		pins.ul = 1'b1;
		set_limit(2, pins);
		wait_intrpt(2, 1'b1, 20);
		check_intrpt(4'b0100);
		set_limit(2, '0);

		request(CMD_REQ_INTRPT_STATUS, 2, reply);
		check_frame("reply_frame", make_frame(CMD_REQ_INTRPT_STATUS, 2, 40'h3), reply);
		check_status("status_o", 3'b011, reply.data[`MCM_INTRPTS_PER_SLOT-1:0]);

		send_cmd(CMD_CLR_INTRPT, 2, 40'h7);
		wait_intrpt(2, 1'b0, 20);
		check_intrpt('0);
		request(CMD_REQ_INTRPT_STATUS, 2, reply);
		check_status("status_o", 3'b000, reply.data[`MCM_INTRPTS_PER_SLOT-1:0]);
		report_test("interrupts", e);
	endtask

	task automatic test_bad_frame();
		int         e;
		spi_frame_t reply;
		e = errors;
		// low data bits left in the shift register read as a slot 0 load
		// once 40 more bits push them up into cmd and addr
		send_cmd(CMD_NOP, 0, 40'h0000000100);
		// cut off after 40 bits, must not load
		spi_xfer(make_frame(CMD_SET_QUAD_COUNT, 0, {8'h00, next_rand()}), 40, reply);
		request(CMD_REQ_QUAD_COUNT, 0, reply);
		check_count("count_o", loaded[0], reply.data[`MCM_QUAD_WIDTH-1:0]);
		// no slot 9
		request(CMD_REQ_QUAD_COUNT, 9, reply);
		check_frame("reply_frame", make_frame(CMD_REQ_QUAD_COUNT, 9, '0), reply);
		report_test("bad_frame", e);
	endtask

	// ****************************************
	// main sequence
	// ****************************************

	initial
	begin
		clk = 1'b0;
		rand_state = 32'h2eec;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		rst_n <= 1'b0;
		spi_clk <= 1'b0;
		spi_scsn <= 1'b1;
		spi_mosi <= 1'b0;
		for (int s = 0; s < `MCM_NUM_SLOTS; s++)
		begin
			quad[s] <= '0;
			limit[s] <= '0;
			quad_phase[s] = 0;
			loaded[s] = '0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);

		test_reset();
		test_count_load();
		test_quad_steps();
		test_interrupts();
		test_bad_frame();

		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if ((tests_failed == 0) && (errors == 0))
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: files.f
+incdir+common
common/mcm_pkg.sv
spi/spi_slave.sv
slot/quad_decoder.sv
slot/intrpt_ctrl.sv
src/reply_builder.sv
src/mcm_top.sv
testbench/tb_mcm_top.sv

// File: Makefile
TOP = tb_mcm_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f files.f --Mdir obj_dir

# pass only if the simulation printed the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
